/* design/grid_overlay_pkg.sv */
`default_nettype none

package grid_overlay_pkg;

    typedef logic [9:0] h_pos_t;
    typedef logic [8:0] v_pos_t;
    typedef logic [3:0] band_t;
    typedef logic [3:0] glyph_code_t;    // 0..9 digits, 15 space
    typedef logic [2:0] glyph_row_sel_t;
    typedef logic [5:0] glyph_row_t;     // msb is the leftmost pixel
    typedef logic [1:0] char_col_t;
    typedef logic [2:0] pix_col_t;

    // plot geometry
    localparam int V_ACTIVE = 480;
    localparam int H_ACTIVE_START = 32;
    localparam int H_ACTIVE_END = 800;   // exclusive
    localparam int BAND_HEIGHT = 40;
    localparam int NUM_BANDS = 12;
    localparam int LAST_GRID_LINE = 479;
    localparam int DOT_BIT = 2;          // dotted line pattern

    // label text
    localparam int LABEL_TOP_OFFSET = 9; // first glyph row above the band's grid line
    localparam int GLYPH_ROWS = 7;
    localparam int GLYPH_WIDTH = 6;
    localparam int LABEL_CHARS = 4;
    localparam int LABEL_STEP = 200;
    localparam int BLANK_CODE = 15;

    // input to registered output, in clocks
    localparam int PIPE_LATENCY = 4;

endpackage

`default_nettype wire

/* design/overlay_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface overlay_if;

    logic grid_valid;
    logic grid_dot;
    logic in_active;
    logic label_valid;
    logic label_pix;

    modport grid_src (output grid_valid, output grid_dot, output in_active);

    modport label_src (output label_valid, output label_pix);

    // both valids line up, the mixer only trusts grid_valid
    modport mixer (
        input grid_valid,
        input grid_dot,
        input in_active,
        input label_valid,
        input label_pix
    );

endinterface

`default_nettype wire

/* design/label_locator.sv */
`timescale 1ns/1ps
`default_nettype none

module label_locator (
    input  logic                             CK,
    input  logic                             arst_n,
    input  logic                             en,
    input  grid_overlay_pkg::h_pos_t         h_pos,
    input  grid_overlay_pkg::v_pos_t         v_pos,
    output grid_overlay_pkg::band_t          band,
    output grid_overlay_pkg::glyph_row_sel_t row,
    output grid_overlay_pkg::char_col_t      col,
    output grid_overlay_pkg::pix_col_t       pix_col,
    output logic                             in_label
);

    logic [8:0] band_w;
    logic [5:0] off_w;    // line inside the band
    logic [4:0] h_lo;
    logic       text_line;
    logic       text_col;

    always_comb begin
        band_w = v_pos / 9'(grid_overlay_pkg::BAND_HEIGHT);
        off_w  = 6'(v_pos - band_w * 9'(grid_overlay_pkg::BAND_HEIGHT));
        h_lo   = h_pos[4:0];

        // glyph rows sit just above the next grid line
        text_line = (off_w >= 6'(grid_overlay_pkg::BAND_HEIGHT - grid_overlay_pkg::LABEL_TOP_OFFSET))
            && (off_w < 6'(grid_overlay_pkg::BAND_HEIGHT - grid_overlay_pkg::LABEL_TOP_OFFSET
                           + grid_overlay_pkg::GLYPH_ROWS))
            && (band_w < 9'(grid_overlay_pkg::NUM_BANDS));
        text_col = h_pos < 10'(grid_overlay_pkg::LABEL_CHARS * grid_overlay_pkg::GLYPH_WIDTH);
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            in_label <= 1'b0;
        end else if (en) begin
            in_label <= text_line & text_col;
        end
    end

    // only meaningful while in_label is set
    always_ff @(posedge CK) begin
        if (en) begin
            band    <= grid_overlay_pkg::band_t'(band_w);
            row     <= grid_overlay_pkg::glyph_row_sel_t'(off_w
                - 6'(grid_overlay_pkg::BAND_HEIGHT - grid_overlay_pkg::LABEL_TOP_OFFSET));
            col     <= grid_overlay_pkg::char_col_t'(h_lo / 5'(grid_overlay_pkg::GLYPH_WIDTH));
            pix_col <= grid_overlay_pkg::pix_col_t'(h_lo % 5'(grid_overlay_pkg::GLYPH_WIDTH));
        end
    end

endmodule

`default_nettype wire

/* design/label_char_map.sv */
`timescale 1ns/1ps
`default_nettype none

module label_char_map (
    input  logic                          CK,
    input  logic                          arst_n,
    input  logic                          en,
    input  grid_overlay_pkg::band_t       band,
    input  grid_overlay_pkg::char_col_t   col,
    input  logic                          in_label,
    output grid_overlay_pkg::glyph_code_t code
);

    logic [15:0] chars;   // four codes, leftmost char in the top nibble

    // band k shows (11-k) steps of LABEL_STEP, f is a blank cell
    always_comb begin
        case (band)
            4'd0:    chars = 16'h2200;
            4'd1:    chars = 16'h2000;
            4'd2:    chars = 16'h1800;
            4'd3:    chars = 16'h1600;
            4'd4:    chars = 16'h1400;
            4'd5:    chars = 16'h1200;
            4'd6:    chars = 16'h1000;
            4'd7:    chars = 16'hf800;
            4'd8:    chars = 16'hf600;
            4'd9:    chars = 16'hf400;
            4'd10:   chars = 16'hf200;
            4'd11:   chars = 16'hfff0;
            default: chars = {grid_overlay_pkg::LABEL_CHARS{4'(grid_overlay_pkg::BLANK_CODE)}};
        endcase
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            code <= grid_overlay_pkg::glyph_code_t'(grid_overlay_pkg::BLANK_CODE);
        end else if (en) begin
            if (in_label) begin
                code <= chars[(3 - int'(col)) * 4 +: 4];
            end else begin
                code <= grid_overlay_pkg::glyph_code_t'(grid_overlay_pkg::BLANK_CODE);
            end
        end
    end

endmodule

`default_nettype wire

/* design/glyph_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module glyph_rom (
    input  logic                             CK,
    input  logic                             en,
    input  grid_overlay_pkg::glyph_code_t    code,
    input  grid_overlay_pkg::glyph_row_sel_t row,
    output grid_overlay_pkg::glyph_row_t     bits
);

    logic [47:0] glyph;   // rows 0..7 from the top, row 7 stays empty

    always_comb begin
        case (code)
            4'd0:    glyph = 48'b001110_010001_010011_010101_011001_010001_001110_000000;
            4'd1:    glyph = 48'b000110_001100_000100_000100_000100_000100_001110_000000;
            4'd2:    glyph = 48'b001110_010001_000001_000010_000100_001000_011111_000000;
            4'd3:    glyph = 48'b001110_010001_000001_000110_000001_011001_001111_000000;
            4'd4:    glyph = 48'b000010_000110_001010_010010_011111_000010_000010_000000;
            4'd5:    glyph = 48'b011111_010000_010000_011110_000001_000001_011110_000000;
            4'd6:    glyph = 48'b000011_000100_001000_011110_010001_010001_001110_000000;
            4'd7:    glyph = 48'b011111_010001_000001_000010_000100_001000_010000_000000;
            4'd8:    glyph = 48'b001110_010001_010001_011110_010001_010001_001110_000000;
            4'd9:    glyph = 48'b001110_010001_010001_001111_000010_000100_011000_000000;
            default: glyph = '0;   // space and unused codes
        endcase
    end

    always_ff @(posedge CK) begin
        if (en) begin
            bits <= glyph[(7 - int'(row)) * grid_overlay_pkg::GLYPH_WIDTH +: 6];
        end
    end

endmodule

`default_nettype wire

/* design/label_text_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module label_text_gen (
    input  logic                     CK,
    input  logic                     arst_n,
    input  logic                     pix_valid,
    input  grid_overlay_pkg::h_pos_t h_pos,
    input  grid_overlay_pkg::v_pos_t v_pos,
    overlay_if.label_src             ovl
);

    logic                             vld1;
    logic                             vld2;
    logic                             vld3;
    grid_overlay_pkg::band_t          band;
    grid_overlay_pkg::glyph_row_sel_t row;
    grid_overlay_pkg::glyph_row_sel_t row_d1;
    grid_overlay_pkg::char_col_t      col;
    grid_overlay_pkg::pix_col_t       pix_col;
    logic                             in_label;
    grid_overlay_pkg::glyph_code_t    code;
    grid_overlay_pkg::glyph_row_t     rom_bits;
    grid_overlay_pkg::pix_col_t       pix_col_d1;
    grid_overlay_pkg::pix_col_t       pix_col_d2;
    logic                             in_label_d1;
    logic                             in_label_d2;

    label_locator u_label_locator (
        .CK       (CK),
        .arst_n   (arst_n),
        .en       (pix_valid),
        .h_pos    (h_pos),
        .v_pos    (v_pos),
        .band     (band),
        .row      (row),
        .col      (col),
        .pix_col  (pix_col),
        .in_label (in_label)
    );

    label_char_map u_label_char_map (
        .CK       (CK),
        .arst_n   (arst_n),
        .en       (vld1),
        .band     (band),
        .col      (col),
        .in_label (in_label),
        .code     (code)
    );

    glyph_rom u_glyph_rom (
        .CK   (CK),
        .en   (vld2),
        .code (code),
        .row  (row_d1),
        .bits (rom_bits)
    );

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            vld1        <= 1'b0;
            vld2        <= 1'b0;
            vld3        <= 1'b0;
            in_label_d1 <= 1'b0;
            in_label_d2 <= 1'b0;
        end else begin
            vld1 <= pix_valid;
            vld2 <= vld1;
            vld3 <= vld2;
            if (vld1) in_label_d1 <= in_label;
            if (vld2) in_label_d2 <= in_label_d1;
        end
    end

    // glyph row waits one stage for its code
    always_ff @(posedge CK) begin
        if (vld1) row_d1 <= row;
    end

    // pixel column rides along until the rom row is out
    always_ff @(posedge CK) begin
        if (vld1) pix_col_d1 <= pix_col;
        if (vld2) pix_col_d2 <= pix_col_d1;
    end

    assign ovl.label_valid = vld3;
    // column 0 is the msb
    assign ovl.label_pix = in_label_d2
        & rom_bits[grid_overlay_pkg::GLYPH_WIDTH - 1 - int'(pix_col_d2)];

endmodule

`default_nettype wire

/* design/grid_line_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_line_gen (
    input  logic                     CK,
    input  logic                     arst_n,
    input  logic                     pix_valid,
    input  grid_overlay_pkg::h_pos_t h_pos,
    input  grid_overlay_pkg::v_pos_t v_pos,
    overlay_if.grid_src              ovl
);

    logic       grid_row;
    logic       in_window;
    logic [2:0] vld_q;
    logic [2:0] row_q;
    logic [2:0] dot_q;
    logic [2:0] win_q;

    // multiples of the band height from 40 to 440, plus the bottom line
    always_comb begin
        grid_row = ((v_pos % 9'(grid_overlay_pkg::BAND_HEIGHT)) == '0)
            && (v_pos >= 9'(grid_overlay_pkg::BAND_HEIGHT))
            && (v_pos <= 9'(grid_overlay_pkg::BAND_HEIGHT * (grid_overlay_pkg::NUM_BANDS - 1)));
        grid_row = grid_row || (v_pos == 9'(grid_overlay_pkg::LAST_GRID_LINE));

        in_window = (v_pos < 9'(grid_overlay_pkg::V_ACTIVE))
            && (h_pos >= 10'(grid_overlay_pkg::H_ACTIVE_START))
            && (h_pos < 10'(grid_overlay_pkg::H_ACTIVE_END));
    end

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], pix_valid};
        end
    end

    // stage 1 decode, stages 2 and 3 only wait for the label path
    always_ff @(posedge CK) begin
        row_q <= {row_q[1:0], grid_row};
        dot_q <= {dot_q[1:0], h_pos[grid_overlay_pkg::DOT_BIT]};
        win_q <= {win_q[1:0], in_window};
    end

    assign ovl.grid_valid = vld_q[2];
    assign ovl.grid_dot   = row_q[2] & dot_q[2];
    assign ovl.in_active  = win_q[2];

endmodule

`default_nettype wire

/* design/pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  logic     CK,
    input  logic     arst_n,
    overlay_if.mixer ovl,
    output logic     out_valid,
    output logic     pix,
    output logic     active
);

    always_ff @(posedge CK or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            pix       <= 1'b0;
            active    <= 1'b0;
        end else begin
            out_valid <= ovl.grid_valid;
            pix       <= ovl.grid_valid & (ovl.grid_dot | ovl.label_pix);
            active    <= ovl.grid_valid & ovl.in_active;
        end
    end

    // grid and label paths must stay in lock step
    a_paths_aligned: assert property (
        @(posedge CK) disable iff (!arst_n) ovl.grid_valid == ovl.label_valid
    );

    // no stray pixels between accepted positions
    a_quiet_when_idle: assert property (
        @(posedge CK) disable iff (!arst_n) !out_valid |-> (!pix && !active)
    );

endmodule

`default_nettype wire

/* design/grid_overlay_top.sv */
`timescale 1ns/1ps
`default_nettype none

module grid_overlay_top (
    input  logic                     CK,
    input  logic                     arst_n,
    input  logic                     pix_valid,
    input  grid_overlay_pkg::h_pos_t h_pos,
    input  grid_overlay_pkg::v_pos_t v_pos,
    output logic                     out_valid,
    output logic                     pix,
    output logic                     active
);

    overlay_if u_ovl ();

    // grid dots and active window
    grid_line_gen u_grid_line_gen (
        .CK        (CK),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .h_pos     (h_pos),
        .v_pos     (v_pos),
        .ovl       (u_ovl.grid_src)
    );

    // y-axis label text
    label_text_gen u_label_text_gen (
        .CK        (CK),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .h_pos     (h_pos),
        .v_pos     (v_pos),
        .ovl       (u_ovl.label_src)
    );

    pixel_mixer u_pixel_mixer (
        .CK        (CK),
        .arst_n    (arst_n),
        .ovl       (u_ovl.mixer),
        .out_valid (out_valid),
        .pix       (pix),
        .active    (active)
    );

endmodule

`default_nettype wire

/* testbench/tb_grid_overlay_tasks.svh */
`ifndef TB_GRID_OVERLAY_TASKS_SVH
`define TB_GRID_OVERLAY_TASKS_SVH

int exp_cyc_q[$];
bit exp_pix_q[$];
bit exp_act_q[$];

// glyph '2', top and bottom rows only
localparam logic [5:0] TWO_ROW0 = 6'b001110;
localparam logic [5:0] TWO_ROW6 = 6'b011111;

function automatic logic [5:0] zero_row(input int r);
    case (r)
        0: return 6'b001110;
        1: return 6'b010001;
        2: return 6'b010011;
        3: return 6'b010101;
        4: return 6'b011001;
        5: return 6'b010001;
        default: return 6'b001110;
    endcase
endfunction

function automatic bit window_ref(input int h, input int v);
    return (v < 480) && (h >= 32) && (h <= 799);
endfunction

function automatic bit dot_ref(input int h, input int v);
    bit row;
    row = ((v % 40) == 0 && v >= 40 && v <= 440) || (v == 479);
    return row && (((h >> 2) & 1) == 1);
endfunction

task automatic drive_pixel(input int h, input int v, input bit exp_pix, input bit exp_act);
    pix_valid = 1'b1;
    h_pos     = 10'(h);
    v_pos     = 9'(v);
    exp_cyc_q.push_back(cyc + grid_overlay_pkg::PIPE_LATENCY);
    exp_pix_q.push_back(exp_pix);
    exp_act_q.push_back(exp_act);
    @(negedge CK);
endtask

task automatic idle_cycles(input int n);
    pix_valid = 1'b0;
    repeat (n) @(negedge CK);
endtask

task automatic drain();
    pix_valid = 1'b0;
    while (exp_cyc_q.size() != 0) @(negedge CK);
    @(negedge CK);
endtask

task automatic compare_output();
    int e_cyc;
    bit e_pix;
    bit e_act;
    if (exp_cyc_q.size() != 0 && exp_cyc_q[0] < cyc) begin
        errors++;
        $display("no out_valid for the pixel due in cycle %0d", exp_cyc_q[0]);
        void'(exp_cyc_q.pop_front());
        void'(exp_pix_q.pop_front());
        void'(exp_act_q.pop_front());
    end
    if (out_valid) begin
        if (exp_cyc_q.size() == 0) begin
            errors++;
            $display("out_valid at %0t with no pixel in flight", $time);
        end else begin
            e_cyc = exp_cyc_q.pop_front();
            e_pix = exp_pix_q.pop_front();
            e_act = exp_act_q.pop_front();
            checks += 3;
            assert (cyc == e_cyc) else begin
                errors++;
                $display("[ERROR] %0t out_valid cycle exp %0d got %0d", $time, e_cyc, cyc);
            end
            assert (pix == e_pix) else begin
                errors++;
                $display("[ERROR] %0t pix exp %0b got %0b", $time, e_pix, pix);
            end
            assert (active == e_act) else begin
                errors++;
                $display("[ERROR] %0t active exp %0b got %0b", $time, e_act, active);
            end
        end
    end else begin
        checks += 2;
        assert (!pix) else begin
            errors++;
            $display("[ERROR] %0t pix exp 0 got %0b", $time, pix);
        end
        assert (!active) else begin
            errors++;
            $display("[ERROR] %0t active exp 0 got %0b", $time, active);
        end
    end
endtask

task automatic test_reset_latency();
    int seen;
    int seen_cyc;
    int e_cyc;
    bit e_pix;
    bit e_act;
    seen     = 0;
    seen_cyc = -1;
    checks += 3;
    assert (!out_valid) else begin
        errors++;
        $display("[ERROR] %0t out_valid exp 0 got %0b", $time, out_valid);
    end
    assert (!pix) else begin
        errors++;
        $display("[ERROR] %0t pix exp 0 got %0b", $time, pix);
    end
    assert (!active) else begin
        errors++;
        $display("[ERROR] %0t active exp 0 got %0b", $time, active);
    end
    drive_pixel(100, 100, dot_ref(100, 100), window_ref(100, 100));
    pix_valid = 1'b0;
    e_cyc = exp_cyc_q.pop_front();
    e_pix = exp_pix_q.pop_front();
    e_act = exp_act_q.pop_front();
    repeat (8) begin
        @(negedge CK);
        if (out_valid) begin
            seen++;
            seen_cyc = cyc;
            checks += 2;
            assert (pix == e_pix) else begin
                errors++;
                $display("[ERROR] %0t pix exp %0b got %0b", $time, e_pix, pix);
            end
            assert (active == e_act) else begin
                errors++;
                $display("[ERROR] %0t active exp %0b got %0b", $time, e_act, active);
            end
        end
    end
    checks += 2;
    assert (seen == 1) else begin
        errors++;
        $display("[ERROR] %0t out_valid_count exp 1 got %0d", $time, seen);
    end
    assert (seen_cyc == e_cyc) else begin
        errors++;
        $display("[ERROR] %0t out_valid cycle exp %0d got %0d", $time, e_cyc, seen_cyc);
    end
endtask

task automatic test_active_window();
    int hs[8] = '{31, 32, 799, 800, 400, 405, 0, 500};
    int vs[8] = '{100, 100, 100, 100, 480, 479, 0, 300};
    for (int i = 0; i < 8; i++) begin
        drive_pixel(hs[i], vs[i], dot_ref(hs[i], vs[i]), window_ref(hs[i], vs[i]));
    end
    drain();
endtask

task automatic test_grid_lines();
    int rows[4] = '{40, 240, 479, 100};
    for (int r = 0; r < 4; r++) begin
        for (int h = 40; h <= 55; h++) begin
            drive_pixel(h, rows[r], dot_ref(h, rows[r]), window_ref(h, rows[r]));
        end
    end
    drain();
endtask

task automatic test_label_zero();
    logic [5:0] bits;
    bit         lit;
    for (int v = 470; v <= 478; v++) begin
        for (int h = 0; h <= 23; h++) begin
            lit = 1'b0;
            if (v >= 471 && v <= 477 && h >= 18) begin
                bits = zero_row(v - 471);
                lit  = bits[5 - (h - 18)];
            end
            drive_pixel(h, v, lit, window_ref(h, v));
        end
    end
    drain();
endtask

task automatic test_label_2200();
    logic [5:0] zero_top;
    zero_top = zero_row(0);
    for (int h = 0; h < 6; h++) begin
        drive_pixel(h, 31, TWO_ROW0[5 - h], window_ref(h, 31));
    end
    for (int h = 0; h < 6; h++) begin
        drive_pixel(h, 37, TWO_ROW6[5 - h], window_ref(h, 37));
    end
    for (int h = 12; h < 18; h++) begin
        drive_pixel(h, 31, zero_top[5 - (h - 12)], window_ref(h, 31));
    end
    drain();
endtask

task automatic test_streaming();
    int h;
    int v;
    for (int i = 0; i < PIXELS_STREAM; i++) begin
        h = 24 + int'($unsigned($random(seed)) % 776);
        v = int'($unsigned($random(seed)) % 511);
        if (((v % 40) == 0 && v >= 40 && v <= 440) || v == 479) v = v + 1;   // skip grid rows
        drive_pixel(h, v, 1'b0, window_ref(h, v));
        if (($random(seed) & 1) != 0) idle_cycles(1);
    end
    drain();
endtask

`endif

/* testbench/tb_grid_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_grid_overlay;

    // pixels driven by each test, in order
    localparam int PIXELS_RESET   = 1;
    localparam int PIXELS_WINDOW  = 8;
    localparam int PIXELS_GRID    = 64;
    localparam int PIXELS_LABEL0  = 216;
    localparam int PIXELS_LABEL22 = 18;
    localparam int PIXELS_STREAM  = 200;
    localparam int TOTAL_PIXELS   = PIXELS_RESET + PIXELS_WINDOW + PIXELS_GRID
        + PIXELS_LABEL0 + PIXELS_LABEL22 + PIXELS_STREAM;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_PIXELS + 200;

    logic                     CK;
    logic                     arst_n;
    logic                     pix_valid;
    grid_overlay_pkg::h_pos_t h_pos;
    grid_overlay_pkg::v_pos_t v_pos;
    logic                     out_valid;
    logic                     pix;
    logic                     active;

    int cyc;
    int errors;
    int checks;
    int seed;
    bit check_en;

    `include "tb_grid_overlay_tasks.svh"

    grid_overlay_top u_grid_overlay_top (
        .CK        (CK),
        .arst_n    (arst_n),
        .pix_valid (pix_valid),
        .h_pos     (h_pos),
        .v_pos     (v_pos),
        .out_valid (out_valid),
        .pix       (pix),
        .active    (active)
    );

    initial begin
        CK = 1'b0;
        forever #20 CK = ~CK;
    end

    always @(posedge CK) begin
        cyc <= cyc + 1;
    end

    // every result is compared where the outputs are stable
    always @(negedge CK) begin
        if (check_en) compare_output();
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, the DUT stopped producing results", cyc);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        seed      = 32'h3d067d7d;
        check_en  = 1'b0;
        arst_n    = 1'b0;
        pix_valid = 1'b0;
        h_pos     = '0;
        v_pos     = '0;

        repeat (8) @(posedge CK);
        @(negedge CK);
        arst_n = 1'b1;

        test_reset_latency();
        check_en = 1'b1;
        test_active_window();
        test_grid_lines();
        test_label_zero();
        test_label_2200();
        test_streaming();

        if (exp_cyc_q.size() != 0) begin
            errors++;
            $display("%0d results never arrived", exp_cyc_q.size());
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
design/grid_overlay_pkg.sv
design/overlay_if.sv
design/label_locator.sv
design/label_char_map.sv
design/glyph_rom.sv
design/label_text_gen.sv
design/grid_line_gen.sv
design/pixel_mixer.sv
design/grid_overlay_top.sv
testbench/tb_grid_overlay.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_grid_overlay
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
